// File: sources.f
logic/i2f_pkg.sv
logic/i2f_ifs.sv
logic/lzc.sv
logic/i2f_input_stage.sv
logic/i2f_normalizer.sv
logic/i2f_round_pack.sv
logic/i2f_top.sv
verification/i2f_checker.sv
verification/i2f_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the converter testbench with Verilator, run it and judge the result from its output

cd "$(dirname "$0")" || exit 1

sim_out=$(verilator --binary --timing -Wno-fatal -f sources.f \
            --top-module i2f_tb -o i2f_sim && ./obj_dir/i2f_sim) \
  || { echo "Build or simulation run did not complete"; echo "$sim_out"; exit 1; }

echo "$sim_out"

echo "$sim_out" | grep -q "^Test passed$" && exit 0 || exit 1

// File: verification/i2f_tb.sv
/*
 * Testbench for the integer to binary32 converter
 * Runs a table of directed cases, then back-to-back random inputs
 */
`default_nettype none
`timescale 1ns/10ps

module i2f_tb;

  localparam int unsigned INT_WIDTH   = 32;
  localparam int unsigned TBL_LEN     = 16;
  localparam int unsigned RAND_ITEMS  = 300;
  localparam int unsigned DRAIN_LIMIT = 50;

  logic            clk;
  logic            rst_n;
  logic            valid;
  logic            sgn;
  logic [31:0]     int_val;
  logic            exp_valid;
  logic [32:0]     exp_value;
  logic            valid_out;
  i2f_pkg::float_t float_out;
  logic            inexact_out;
  int              value_errs;
  int              protocol_errs;
  int              pending;
  int              timeout_errs;

  // Directed cases with their expected word and inexact flag
  logic        tbl_signed  [TBL_LEN];
  logic [31:0] tbl_int     [TBL_LEN];
  logic [31:0] tbl_float   [TBL_LEN];
  logic        tbl_inexact [TBL_LEN];
  int          tbl_gap     [TBL_LEN];

  i2f_top #(
    .INT_WIDTH (INT_WIDTH)
  ) u_i2f_top (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .valid_i   (valid),
    .signed_i  (sgn),
    .int_i     (int_val),
    .valid_o   (valid_out),
    .float_o   (float_out),
    .inexact_o (inexact_out)
  );

  i2f_checker #(
    .INT_WIDTH (INT_WIDTH)
  ) u_checker (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .valid_i         (valid),
    .signed_i        (sgn),
    .int_i           (int_val),
    .exp_valid_i     (exp_valid),
    .exp_value_i     (exp_value),
    .dut_valid_i     (valid_out),
    .dut_float_i     (float_out),
    .dut_inexact_i   (inexact_out),
    .value_errs_o    (value_errs),
    .protocol_errs_o (protocol_errs),
    .pending_o       (pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic set_entry(input int idx, input logic s, input logic [31:0] v,
                           input logic [31:0] f, input logic x, input int gap);
    tbl_signed[idx]  = s;
    tbl_int[idx]     = v;
    tbl_float[idx]   = f;
    tbl_inexact[idx] = x;
    tbl_gap[idx]     = gap;
  endtask

  task automatic load_table();
    // Exact values, zero and plus or minus one
    set_entry(0,  1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 0);
    set_entry(1,  1'b0, 32'h0000_0001, 32'h3F80_0000, 1'b0, 2);
    set_entry(2,  1'b1, 32'hFFFF_FFFF, 32'hBF80_0000, 1'b0, 0);
    set_entry(3,  1'b0, 32'h0100_0000, 32'h4B80_0000, 1'b0, 1);
    // All ones unsigned rounds up into the next exponent
    set_entry(4,  1'b0, 32'hFFFF_FFFF, 32'h4F80_0000, 1'b1, 0);
    // Most negative signed value is exact
    set_entry(5,  1'b1, 32'h8000_0000, 32'hCF00_0000, 1'b0, 3);
    // Ties, one toward an even LSB below and one above
    set_entry(6,  1'b0, 32'h0100_0001, 32'h4B80_0000, 1'b1, 0);
    set_entry(7,  1'b0, 32'h0100_0003, 32'h4B80_0002, 1'b1, 0);
    // Guard and sticky set, then guard clear with sticky set
    set_entry(8,  1'b0, 32'h0200_0003, 32'h4C00_0001, 1'b1, 1);
    set_entry(9,  1'b0, 32'h0200_0001, 32'h4C00_0000, 1'b1, 0);
    set_entry(10, 1'b1, 32'hFEFF_FFFF, 32'hCB80_0000, 1'b1, 0);
    // Tie with an odd LSB goes up
    set_entry(11, 1'b0, 32'h0200_0006, 32'h4C00_0002, 1'b1, 2);
    set_entry(12, 1'b0, 32'h7FFF_FFFF, 32'h4F00_0000, 1'b1, 0);
    set_entry(13, 1'b1, 32'h7FFF_FFFF, 32'h4F00_0000, 1'b1, 0);
    set_entry(14, 1'b0, 32'h00FF_FFFF, 32'h4B7F_FFFF, 1'b0, 1);
    set_entry(15, 1'b1, 32'hFFFF_FFFE, 32'hC000_0000, 1'b0, 0);
  endtask

  // One item presented for exactly one edge of the DUT
  task automatic send_item(input logic s, input logic [31:0] v, input logic has_exp,
                           input logic [32:0] e);
    @(posedge clk);
    valid     <= 1'b1;
    sgn       <= s;
    int_val   <= v;
    exp_valid <= has_exp;
    exp_value <= e;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      valid     <= 1'b0;
      exp_valid <= 1'b0;
    end
  endtask

  // A random shift spreads the leading one over all positions
  function automatic logic [31:0] random_operand();
    logic [31:0] raw;
    raw = $urandom;
    return raw >> $urandom_range(0, 31);
  endfunction

  // Sampled on the falling edge, away from the checker's update
  task automatic wait_for_drain(output logic drained);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (pending != 0 && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    drained = (pending == 0);
  endtask

  initial begin
    int unsigned seed_ret;
    logic        drained;
    clk_setup_done: begin
      rst_n        = 1'b0;
      valid        = 1'b0;
      sgn          = 1'b0;
      int_val      = '0;
      exp_valid    = 1'b0;
      exp_value    = '0;
      timeout_errs = 0;
    end
    seed_ret = $urandom(32'hd254_0008);
    load_table();

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    idle_cycles(2);

    for (int i = 0; i < TBL_LEN; i++) begin
      send_item(tbl_signed[i], tbl_int[i], 1'b1, {tbl_inexact[i], tbl_float[i]});
      idle_cycles(tbl_gap[i]);
    end

    // Back-to-back random items check throughput and order
    for (int i = 0; i < RAND_ITEMS; i++) begin
      send_item(1'($urandom_range(0, 1)), random_operand(), 1'b0, 33'd0);
    end
    idle_cycles(2);

    wait_for_drain(drained);
    if (!drained) begin
      $display("Timeout: %0d results never came out of the DUT", pending);
      timeout_errs++;
    end
    // Any stray valid_o in this quiet period is flagged by the checker
    idle_cycles(8);

    $display("Errors: %0d value, %0d protocol, %0d timeout",
             value_errs, protocol_errs, timeout_errs);
    if (value_errs == 0 && protocol_errs == 0 && timeout_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : i2f_tb

`default_nettype wire

// File: verification/i2f_checker.sv
/*
 * Result checker for the integer to binary32 converter
 * Models every accepted input, compares the DUT results in order and counts errors
 */
`default_nettype none
`timescale 1ns/10ps

module i2f_checker #(
  parameter int unsigned INT_WIDTH = 32
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 valid_i,
  input  wire logic                 signed_i,
  input  wire logic [INT_WIDTH-1:0] int_i,
  input  wire logic                 exp_valid_i,
  input  wire logic [32:0]          exp_value_i,
  input  wire logic                 dut_valid_i,
  input  wire logic [31:0]          dut_float_i,
  input  wire logic                 dut_inexact_i,
  output int                        value_errs_o,
  output int                        protocol_errs_o,
  output int                        pending_o
);

  // Model results as {inexact, word}, table entries as {present, inexact, word}
  logic [32:0] ref_q [$];
  logic [33:0] tbl_q [$];
  int          value_errs    = 0;
  int          protocol_errs = 0;
  int          pending       = 0;

  assign value_errs_o    = value_errs;
  assign protocol_errs_o = protocol_errs;
  assign pending_o       = pending;

  // Reference conversion done with plain integer arithmetic on a wide magnitude
  function automatic logic [32:0] convert_ref(input logic sgn_mode,
                                              input logic [INT_WIDTH-1:0] val);
    logic        neg;
    logic [63:0] mag;
    logic [63:0] keep;
    logic [63:0] rem;
    logic [63:0] half;
    int          msb;
    int          shift;
    logic [8:0]  biased;
    logic        lost;
    neg = sgn_mode & val[INT_WIDTH-1];
    mag = neg ? ((64'd1 << INT_WIDTH) - 64'(val)) : 64'(val);
    if (mag == 64'd0) begin
      return 33'd0;
    end
    msb = 0;
    for (int b = 0; b < 64; b++) begin
      if (mag[b]) begin
        msb = b;
      end
    end
    biased = 9'(127 + msb);
    lost   = 1'b0;
    if (msb <= 23) begin
      // Fits in the significand, nothing is dropped
      keep = mag << (23 - msb);
    end else begin
      shift = msb - 23;
      keep  = mag >> shift;
      rem   = mag & ((64'd1 << shift) - 64'd1);
      half  = 64'd1 << (shift - 1);
      lost  = (rem != 64'd0);
      // Nearest value wins, an exact half goes to the even significand
      if (rem > half || (rem == half && keep[0])) begin
        keep = keep + 64'd1;
      end
      // Rounding past 2^24 moves up one binade
      if (keep[24]) begin
        keep   = keep >> 1;
        biased = biased + 9'd1;
      end
    end
    return {lost, neg, biased[7:0], keep[22:0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
               $time, name, got, want);
      value_errs++;
    end
  endtask

  // One result leaves the DUT, so the oldest model entry is due
  task automatic compare_output();
    logic [32:0] want;
    logic [33:0] tbl;
    if (ref_q.size() == 0) begin
      $display("ERROR at %0t: valid_o pulsed while no input was waiting for a result",
               $time);
      protocol_errs++;
    end else begin
      want = ref_q.pop_front();
      tbl  = tbl_q.pop_front();
      check_value("float_o", dut_float_i, want[31:0]);
      check_value("inexact_o", {31'd0, dut_inexact_i}, {31'd0, want[32]});
      // Table entries are checked against their hand-derived values as well
      if (tbl[33]) begin
        check_value("float_o (table)", dut_float_i, tbl[31:0]);
        check_value("inexact_o (table)", {31'd0, dut_inexact_i}, {31'd0, tbl[32]});
      end
    end
  endtask

  // Inputs are driven just after the edge, so the values seen here are settled
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      ref_q.delete();
      tbl_q.delete();
    end else begin
      if (dut_valid_i) begin
        compare_output();
      end
      if (valid_i) begin
        ref_q.push_back(convert_ref(signed_i, int_i));
        tbl_q.push_back({exp_valid_i, exp_value_i});
      end
    end
    pending = ref_q.size();
  end

endmodule : i2f_checker

`default_nettype wire

// File: logic/i2f_top.sv
/*
 * Integer to binary32 converter
 * Three register stages, one item per cycle, results in order after three cycles
 */
`default_nettype none
`timescale 1ns/10ps

module i2f_top #(
  parameter int unsigned INT_WIDTH = 32
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 valid_i,
  input  wire logic                 signed_i,
  input  wire logic [INT_WIDTH-1:0] int_i,
  output logic                      valid_o,
  output i2f_pkg::float_t           float_o,
  output logic                      inexact_o
);

  // Bundles between the stages
  mag_if  #(.INT_WIDTH(INT_WIDTH)) u_mag_if ();
  norm_if #(.INT_WIDTH(INT_WIDTH)) u_norm_if ();

  // Sign and magnitude
  i2f_input_stage #(
    .INT_WIDTH (INT_WIDTH)
  ) u_input_stage (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .signed_i (signed_i),
    .int_i    (int_i),
    .mag_o    (u_mag_if.src)
  );

  // Leading zero count and shift
  i2f_normalizer #(
    .INT_WIDTH (INT_WIDTH)
  ) u_normalizer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .mag_i   (u_mag_if.dst),
    .norm_o  (u_norm_if.src)
  );

  // Rounding and packing
  i2f_round_pack u_round_pack (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .norm_i    (u_norm_if.dst),
    .valid_o   (valid_o),
    .float_o   (float_o),
    .inexact_o (inexact_o)
  );

endmodule : i2f_top

`default_nettype wire

// File: logic/i2f_round_pack.sv
/*
 * Round and pack stage of the integer to binary32 converter
 * Rounds to nearest even, packs the binary32 word and reports inexact results
 */
`default_nettype none
`timescale 1ns/10ps

module i2f_round_pack (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  norm_if.dst            norm_i,
  output logic           valid_o,
  output i2f_pkg::float_t float_o,
  output logic           inexact_o
);

  localparam int unsigned SIG_W = i2f_pkg::MANT_W + 1;

  logic             round_up;
  logic [SIG_W:0]   sig_sum;
  logic             carry;
  i2f_pkg::exp_t    exp_rnd;
  i2f_pkg::float_t  packed_word;

  // Above half always rounds up, an exact tie only when the LSB is odd
  assign round_up = norm_i.guard & (norm_i.sticky | norm_i.sig[0]);

  // One spare bit catches the carry out of an all-ones significand
  assign sig_sum = {1'b0, norm_i.sig} + (SIG_W + 1)'(round_up);
  assign carry   = sig_sum[SIG_W];

  // On a carry the sum is a lone one above the hidden bit, so the fraction is already zero
  assign exp_rnd = norm_i.exp + i2f_pkg::exp_t'(carry);

  always_comb begin
    if (norm_i.zero) begin
      packed_word = {i2f_pkg::FLOAT_W{1'b0}};
    end else begin
      packed_word = {norm_i.sign, exp_rnd, sig_sum[i2f_pkg::MANT_W-1:0]};
    end
  end

  // Control outputs are cleared by reset and only pulse with an item
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o   <= 1'b0;
      inexact_o <= 1'b0;
    end else begin
      valid_o   <= norm_i.valid;
      inexact_o <= norm_i.valid & (norm_i.guard | norm_i.sticky);
    end
  end

  // The result word holds between items
  always_ff @(posedge clk_i) begin
    if (norm_i.valid) begin
      float_o <= packed_word;
    end
  end

  // A zero item drops no bits upstream, so +0.0 never leaves with inexact set
  a_zero_is_exact : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (norm_i.valid && norm_i.zero) |-> !(norm_i.guard || norm_i.sticky)
  ) else $error("round_pack: zero item arrived with guard or sticky set");

endmodule : i2f_round_pack

`default_nettype wire

// File: logic/i2f_normalizer.sv
/*
 * Normalizer stage of the integer to binary32 converter
 * Moves the leading one to the top and derives exponent, significand, guard and sticky
 */
`default_nettype none
`timescale 1ns/10ps

module i2f_normalizer #(
  parameter int unsigned INT_WIDTH = 32
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  mag_if.dst        mag_i,
  norm_if.src       norm_o
);

  localparam int unsigned CNT_W = $clog2(INT_WIDTH);
  localparam int unsigned SIG_W = i2f_pkg::MANT_W + 1;
  // Enough room below the magnitude for a full significand and the guard bit
  localparam int unsigned EXT_W = INT_WIDTH + SIG_W + 1;
  // Exponent of a value whose leading one is already the MSB
  localparam i2f_pkg::exp_t EXP_TOP = i2f_pkg::exp_t'(i2f_pkg::EXP_BIAS + INT_WIDTH - 1);

  logic [CNT_W-1:0]     lz_cnt;
  logic                 lz_empty;
  logic [INT_WIDTH-1:0] shifted;
  logic [EXT_W-1:0]     ext;
  i2f_pkg::exp_t        exp_calc;

  lzc #(
    .WIDTH (INT_WIDTH)
  ) u_lzc (
    .in_i    (mag_i.mag),
    .cnt_o   (lz_cnt),
    .empty_o (lz_empty)
  );

  assign shifted  = mag_i.mag << lz_cnt;
  assign exp_calc = EXP_TOP - i2f_pkg::exp_t'(lz_cnt);

  // Zero fill on the right covers narrow integers, where guard and sticky stay clear
  assign ext = {shifted, {(SIG_W + 1){1'b0}}};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      norm_o.valid <= 1'b0;
    end else begin
      norm_o.valid <= mag_i.valid;
    end
  end

  // For a zero item these fields are don't care, the packer forces +0.0
  always_ff @(posedge clk_i) begin
    if (mag_i.valid) begin
      norm_o.sign   <= mag_i.sign;
      norm_o.zero   <= mag_i.zero;
      norm_o.exp    <= exp_calc;
      norm_o.sig    <= ext[EXT_W-1 -: SIG_W];
      norm_o.guard  <= ext[EXT_W-SIG_W-1];
      norm_o.sticky <= |ext[EXT_W-SIG_W-2:0];
    end
  end

  // The zero flag from the input stage must agree with the counter on every item
  a_zero_matches_lzc : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mag_i.valid |-> (lz_empty == mag_i.zero)
  ) else $error("normalizer: lzc empty flag disagrees with input zero flag");

endmodule : i2f_normalizer

`default_nettype wire

// File: logic/i2f_input_stage.sv
/*
 * Input register stage of the integer to binary32 converter
 * Splits the incoming integer into a sign and an absolute magnitude
 */
`default_nettype none
`timescale 1ns/10ps

module i2f_input_stage #(
  parameter int unsigned INT_WIDTH = 32
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 valid_i,
  input  wire logic                 signed_i,
  input  wire logic [INT_WIDTH-1:0] int_i,
  mag_if.src                        mag_o
);

  logic                 neg;
  logic [INT_WIDTH-1:0] abs_val;
  logic                 is_zero;

  // Only a signed input with its top bit set counts as negative
  assign neg = signed_i & int_i[INT_WIDTH-1];

  // Two's complement negation
  // The most negative value maps onto itself, which is the correct unsigned magnitude
  assign abs_val = neg ? (~int_i + 1'b1) : int_i;

  assign is_zero = ~|int_i;

  // Valid strobe, cleared by reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mag_o.valid <= 1'b0;
    end else begin
      mag_o.valid <= valid_i;
    end
  end

  // Payload only loads with an item and holds otherwise
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mag_o.sign <= neg;
      mag_o.mag  <= abs_val;
      mag_o.zero <= is_zero;
    end
  end

endmodule : i2f_input_stage

`default_nettype wire

// File: logic/lzc.sv
/*
 * Leading zero counter
 * Reduction tree over the bit-reversed input, empty_o flags an all-zero vector
 */
`default_nettype none
`timescale 1ns/10ps

module lzc #(
  parameter int unsigned WIDTH = 32
) (
  input  wire logic [WIDTH-1:0]         in_i,
  output logic      [$clog2(WIDTH)-1:0] cnt_o,
  output logic                          empty_o
);

  localparam int unsigned CNT_W  = $clog2(WIDTH);
  localparam int unsigned LEVELS = $clog2(WIDTH);
  // A full binary tree with one node per pair at the leaf level
  localparam int unsigned NODES  = (2 ** LEVELS) - 1;

  logic [WIDTH-1:0] rev;
  logic [NODES-1:0] sel_nodes;
  logic [CNT_W-1:0] idx_nodes [NODES];

  initial begin
    assert (WIDTH >= 2) else $fatal(1, "lzc: WIDTH must be at least 2");
  end

  // After the reversal the MSB sits at index 0, so the lowest set index is the zero count
  always_comb begin
    for (int unsigned i = 0; i < WIDTH; i++) begin
      rev[i] = in_i[WIDTH-1-i];
    end
  end

  for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
    for (genvar k = 0; k < 2 ** lvl; k++) begin : g_node
      localparam int unsigned NODE = (2 ** lvl) - 1 + k;
      if (lvl == LEVELS - 1) begin : g_leaf
        // Leaves look at input pairs, a short vector leaves some of them half or fully unused
        if (2 * k + 1 < WIDTH) begin : g_pair
          assign sel_nodes[NODE] = rev[2*k] | rev[2*k+1];
          assign idx_nodes[NODE] = rev[2*k] ? CNT_W'(2 * k) : CNT_W'(2 * k + 1);
        end else if (2 * k < WIDTH) begin : g_single
          assign sel_nodes[NODE] = rev[2*k];
          assign idx_nodes[NODE] = CNT_W'(2 * k);
        end else begin : g_unused
          assign sel_nodes[NODE] = 1'b0;
          assign idx_nodes[NODE] = '0;
        end
      end else begin : g_inner
        localparam int unsigned LEFT = (2 ** (lvl + 1)) - 1 + 2 * k;
        // The left child covers lower indices and therefore wins whenever it holds a one
        assign sel_nodes[NODE] = sel_nodes[LEFT] | sel_nodes[LEFT+1];
        assign idx_nodes[NODE] = sel_nodes[LEFT] ? idx_nodes[LEFT] : idx_nodes[LEFT+1];
      end
    end
  end

  // Root of the tree
  assign cnt_o   = idx_nodes[0];
  assign empty_o = ~sel_nodes[0];

endmodule : lzc

`default_nettype wire

// File: logic/i2f_ifs.sv
/*
 * Stage interfaces of the integer to binary32 converter
 * mag_if runs from the input stage to the normalizer, norm_if onward to rounding
 */
`default_nettype none
`timescale 1ns/10ps

interface mag_if #(
  parameter int unsigned INT_WIDTH = 32
);

  // Strobe for one item, no back-pressure exists
  logic                 valid;
  // Set for a negative signed input
  logic                 sign;
  // Absolute value of the input
  logic [INT_WIDTH-1:0] mag;
  // Whole input was zero
  logic                 zero;

  modport src (output valid, sign, mag, zero);
  modport dst (input valid, sign, mag, zero);

endinterface : mag_if

interface norm_if #(
  parameter int unsigned INT_WIDTH = 32
);

  logic                valid;
  logic                sign;
  logic                zero;
  // Exponent before a possible rounding carry
  i2f_pkg::exp_t       exp;
  // Top 24 bits after normalization, the MSB is the hidden one
  i2f_pkg::sig_t       sig;
  // First dropped bit and the OR of everything below it
  logic                guard;
  logic                sticky;

  // The largest exponent that the normalizer can form must stay below the all-ones code
  initial begin
    assert (INT_WIDTH >= 2 && INT_WIDTH - 1 <= i2f_pkg::EXP_BIAS)
      else $fatal(1, "norm_if: INT_WIDTH %0d does not fit binary32", INT_WIDTH);
  end

  modport src (output valid, sign, zero, exp, sig, guard, sticky);
  modport dst (input valid, sign, zero, exp, sig, guard, sticky);

endinterface : norm_if

`default_nettype wire

// File: logic/i2f_pkg.sv
/*
 * Integer to binary32 converter definitions
 * Field widths, exponent bias and the vector types shared by the stages
 */
`default_nettype none

package i2f_pkg;

  // Packed IEEE 754 binary32 word
  localparam int unsigned FLOAT_W = 32;

  // Biased exponent field
  localparam int unsigned EXP_W = 8;

  // Stored fraction, the hidden one is not part of it
  localparam int unsigned MANT_W = 23;

  // Exponent bias of binary32
  localparam int unsigned EXP_BIAS = 127;

  // Whole binary32 word as it leaves the converter
  typedef logic [FLOAT_W-1:0] float_t;

  // Biased exponent as carried between the normalizer and the packer
  typedef logic [EXP_W-1:0] exp_t;

  // Significand including the hidden one at the top
  typedef logic [MANT_W:0] sig_t;

endpackage : i2f_pkg

`default_nettype wire
